//--- build.f
simt_pkg.sv
simt_stage_buf.sv
simt_gpr_bank.sv
simt_decode.sv
simt_operands.sv
simt_alu.sv
simt_result.sv
simt_core.sv
simt_tb.sv

//--- run.sh
#!/bin/sh
# compile the SIMT slice with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module simt_tb -o simt_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/simt_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

//--- simt_alu.sv
////////////////////////////////////////
// SIMT integer execute stage
// one operation per thread lane
////////////////////////////////////////
`timescale 1ns/10ps

module simt_alu (
    input  logic              in_valid,
    output logic              in_ready,
    input  simt_pkg::exec_t   in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output simt_pkg::result_t out_data
);
    import simt_pkg::*;

    lane_data_t a;
    lane_data_t b;
    lane_data_t c;
    lane_data_t lane_res;

    assign a = in_data.rs1_data;
    assign b = in_data.rs2_data;
    assign c = in_data.rs3_data;

    always_comb begin
        lane_res = '0;
        for (int t = 0; t < num_threads; t++) begin
            if (in_data.tmask[t]) begin
                case (in_data.op)
                    op_add:  lane_res[t] = a[t] + b[t];
                    op_sub:  lane_res[t] = a[t] - b[t];
                    op_and:  lane_res[t] = a[t] & b[t];
                    op_or:   lane_res[t] = a[t] | b[t];
                    op_xor:  lane_res[t] = a[t] ^ b[t];
                    op_shl:  lane_res[t] = a[t] << b[t][4:0];
                    op_shr:  lane_res[t] = a[t] >> b[t][4:0];
                    op_mad:  lane_res[t] = a[t] * b[t] + c[t];
                    // each lane sees the immediate offset by its own index
                    op_ldi:  lane_res[t] = xlen'(in_data.imm) + xlen'(t);
                    default: lane_res[t] = '0;
                endcase
            end
        end
    end

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    always_comb begin
        out_data.rd    = in_data.rd;
        out_data.tmask = in_data.tmask;
        out_data.wb    = in_data.wb;
        out_data.data  = lane_res;
    end

endmodule

//--- simt_core.sv
////////////////////////////////////////
// SIMT issue slice top level
// decode, collect, execute, write back
////////////////////////////////////////
`timescale 1ns/10ps

module simt_core #(
    parameter int num_banks = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  logic [31:0]       instr,
    output logic              result_valid,
    input  logic              result_ready,
    output simt_pkg::result_t result
);
    import simt_pkg::*;

    logic    dec_valid;
    logic    dec_ready;
    issue_t  dec_data;
    logic    iss_valid;
    logic    iss_ready;
    issue_t  iss_data;
    logic    opd_valid;
    logic    opd_ready;
    exec_t   opd_data;
    logic    exe_valid;
    logic    exe_ready;
    exec_t   exe_data;
    logic    alu_valid;
    logic    alu_ready;
    result_t alu_data;
    logic    wb_valid;
    wb_t     wb_data;

    simt_decode decode_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .out_valid   (dec_valid),
        .out_ready   (dec_ready),
        .out_data    (dec_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_data.rd)
    );

    simt_stage_buf #(
        .payload_t (issue_t)
    ) issue_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (dec_data),
        .out_valid (iss_valid),
        .out_ready (iss_ready),
        .out_data  (iss_data)
    );

    simt_operands #(
        .num_banks (num_banks)
    ) operands_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (iss_valid),
        .in_ready  (iss_ready),
        .in_data   (iss_data),
        .out_valid (opd_valid),
        .out_ready (opd_ready),
        .out_data  (opd_data),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data)
    );

    simt_stage_buf #(
        .payload_t (exec_t)
    ) exec_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (opd_valid),
        .in_ready  (opd_ready),
        .in_data   (opd_data),
        .out_valid (exe_valid),
        .out_ready (exe_ready),
        .out_data  (exe_data)
    );

    simt_alu alu_inst (
        .in_valid  (exe_valid),
        .in_ready  (exe_ready),
        .in_data   (exe_data),
        .out_valid (alu_valid),
        .out_ready (alu_ready),
        .out_data  (alu_data)
    );

    simt_result result_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (alu_valid),
        .in_ready     (alu_ready),
        .in_data      (alu_data),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .wb_valid     (wb_valid),
        .wb_data      (wb_data)
    );

endmodule

//--- simt_decode.sv
////////////////////////////////////////
// SIMT instruction decode
// field split and register scoreboard
////////////////////////////////////////
`timescale 1ns/10ps

module simt_decode (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         instr_valid,
    output logic                         instr_ready,
    input  logic [31:0]                  instr,
    output logic                         out_valid,
    input  logic                         out_ready,
    output simt_pkg::issue_t             out_data,
    input  logic                         wb_valid,
    input  logic [simt_pkg::nr_bits-1:0] wb_rd
);
    import simt_pkg::*;

    logic [num_regs-1:0] pending;
    opcode_e             op;
    logic                use_rs1;
    logic                use_rs2;
    logic                use_rs3;
    logic                hazard;
    logic                issue;

    assign op = opcode_e'(instr[3:0]);

    // ldi reads nothing and only mad reads a third source
    always_comb begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rs3 = 1'b0;
        case (op)
            op_ldi: begin
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
            end
            op_mad: use_rs3 = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        out_data.op    = op;
        out_data.rd    = instr[8:4];
        out_data.rs1   = use_rs1 ? instr[13:9] : '0;
        out_data.rs2   = use_rs2 ? instr[18:14] : '0;
        out_data.rs3   = use_rs3 ? instr[23:19] : '0;
        out_data.imm   = instr[23:9];
        out_data.tmask = instr[27:24];
        out_data.wb    = (instr[8:4] != '0);
    end

    // masked sources read as register 0, which is never pending
    assign hazard = pending[out_data.rs1] || pending[out_data.rs2]
                 || pending[out_data.rs3] || pending[out_data.rd];

    // nothing issues while reset is held
    assign out_valid   = instr_valid && !hazard && !reset;
    assign instr_ready = out_ready && !hazard && !reset;
    assign issue       = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_rd] <= 1'b0;
            end
            if (issue && out_data.wb) begin
                pending[out_data.rd] <= 1'b1;
            end
        end
    end

endmodule

//--- simt_gpr_bank.sv
////////////////////////////////////////
// SIMT register bank
// lane-masked write, registered read
////////////////////////////////////////
`timescale 1ns/10ps

module simt_gpr_bank #(
    parameter int depth = 8
) (
    input  logic                     clk,
    input  logic                     read,
    input  logic [$clog2(depth)-1:0] raddr,
    output simt_pkg::lane_data_t     rdata,
    input  logic                     write,
    input  simt_pkg::tmask_t         wren,
    input  logic [$clog2(depth)-1:0] waddr,
    input  simt_pkg::lane_data_t     wdata
);
    import simt_pkg::*;

    lane_data_t mem [depth];

    always_ff @(posedge clk) begin
        for (int t = 0; t < num_threads; t++) begin
            if (write && wren[t]) begin
                mem[waddr][t] <= wdata[t];
            end
        end
        // rdata holds its value while no read is issued
        if (read) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- simt_operands.sv
////////////////////////////////////////
// SIMT operand collector
// banked source fetch with retry
////////////////////////////////////////
`timescale 1ns/10ps

module simt_operands #(
    parameter int num_banks = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  simt_pkg::issue_t in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output simt_pkg::exec_t  out_data,
    input  logic             wb_valid,
    input  simt_pkg::wb_t    wb_data
);
    import simt_pkg::*;

    localparam int depth     = num_regs / num_banks;
    localparam int addr_bits = $clog2(depth);
    localparam int bank_bits = (num_banks > 1) ? $clog2(num_banks) : 1;
    localparam int sel_bits  = $clog2(num_src_regs);

    logic [num_src_regs-1:0][nr_bits-1:0]   src_regs;
    logic [num_src_regs-1:0][bank_bits-1:0] src_bank;
    logic [num_src_regs-1:0][addr_bits-1:0] src_addr;
    logic [num_src_regs-1:0]                src_need;
    logic [num_src_regs-1:0]                granted;
    logic [num_src_regs-1:0]                fetched_q;
    logic                                   collision;

    logic [num_banks-1:0]                   bank_req;
    logic [num_banks-1:0][sel_bits-1:0]     bank_sel;
    logic [num_banks-1:0][addr_bits-1:0]    bank_addr;
    lane_data_t [num_banks-1:0]             bank_rdata;
    logic [bank_bits-1:0]                   wb_bank;
    logic [addr_bits-1:0]                   wb_addr;

    logic                                   st1_valid;
    logic                                   st1_ready;
    logic                                   st1_last;
    logic                                   st1_first;
    issue_t                                 st1_meta;
    logic [num_banks-1:0]                   st1_hit;
    logic [num_banks-1:0][sel_bits-1:0]     st1_sel;

    logic                                   st2_valid;
    logic                                   st2_ready;
    issue_t                                 st2_meta;
    lane_data_t [num_src_regs-1:0]          st2_src;
    lane_data_t [num_src_regs-1:0]          src_merged;

    assign src_regs = {in_data.rs3, in_data.rs2, in_data.rs1};

    always_comb begin
        for (int i = 0; i < num_src_regs; i++) begin
            src_bank[i] = bank_bits'(src_regs[i] % num_banks);
            src_addr[i] = addr_bits'(src_regs[i] / num_banks);
            src_need[i] = in_valid && (src_regs[i] != '0) && !fetched_q[i];
        end
    end

    always_comb begin
        bank_req  = '0;
        bank_sel  = '0;
        bank_addr = '0;
        // walking down from the top leaves the lowest-numbered source as winner
        for (int b = 0; b < num_banks; b++) begin
            for (int i = num_src_regs - 1; i >= 0; i--) begin
                if (src_need[i] && (src_bank[i] == bank_bits'(b))) begin
                    bank_req[b]  = 1'b1;
                    bank_sel[b]  = sel_bits'(i);
                    bank_addr[b] = src_addr[i];
                end
            end
        end
        for (int i = 0; i < num_src_regs; i++) begin
            granted[i] = src_need[i] && (bank_sel[src_bank[i]] == sel_bits'(i));
        end
    end

    assign collision = |(src_need & ~granted);

    assign st2_ready = out_ready || !st2_valid;
    assign st1_ready = st2_ready || !st1_valid;
    assign in_ready  = st1_ready && !collision;

    // sources won in earlier rounds are not requested again
    always_ff @(posedge clk) begin
        if (reset) begin
            fetched_q <= '0;
        end else if (st1_ready && in_valid) begin
            fetched_q <= collision ? (fetched_q | granted) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
        end else if (st1_ready) begin
            st1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (st1_ready) begin
            st1_last  <= !collision;
            st1_first <= (fetched_q == '0);
            st1_meta  <= in_data;
            st1_hit   <= bank_req;
            st1_sel   <= bank_sel;
        end
    end

    assign wb_bank = bank_bits'(wb_data.rd % num_banks);
    assign wb_addr = addr_bits'(wb_data.rd / num_banks);

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        simt_gpr_bank #(
            .depth (depth)
        ) bank_inst (
            .clk   (clk),
            .read  (bank_req[b] && st1_ready),
            .raddr (bank_addr[b]),
            .rdata (bank_rdata[b]),
            .write (wb_valid && (wb_bank == bank_bits'(b))),
            .wren  (wb_data.tmask),
            .waddr (wb_addr),
            .wdata (wb_data.data)
        );
    end

    // a retry round adds its data to what the earlier rounds left in stage two
    always_comb begin
        src_merged = st1_first ? '0 : st2_src;
        for (int b = 0; b < num_banks; b++) begin
            if (st1_hit[b]) begin
                src_merged[st1_sel[b]] = bank_rdata[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st2_valid <= 1'b0;
        end else if (st2_ready) begin
            st2_valid <= st1_valid && st1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (st2_ready && st1_valid) begin
            st2_meta <= st1_meta;
            st2_src  <= src_merged;
        end
    end

    assign out_valid = st2_valid;

    always_comb begin
        out_data.op       = st2_meta.op;
        out_data.rd       = st2_meta.rd;
        out_data.tmask    = st2_meta.tmask;
        out_data.wb       = st2_meta.wb;
        out_data.imm      = st2_meta.imm;
        out_data.rs1_data = st2_src[0];
        out_data.rs2_data = st2_src[1];
        out_data.rs3_data = st2_src[2];
    end

endmodule

//--- simt_pkg.sv
////////////////////////////////////////
// SIMT issue slice shared definitions
// widths, opcodes and stage payloads
////////////////////////////////////////
package simt_pkg;

    localparam int xlen         = 32;
    localparam int num_threads  = 4;
    localparam int num_regs     = 32;
    localparam int nr_bits      = 5;
    localparam int num_src_regs = 3;
    localparam int imm_bits     = 15;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_shl = 4'd5,
        op_shr = 4'd6,
        op_mad = 4'd7,
        op_ldi = 4'd8
    } opcode_e;

    typedef logic [num_threads-1:0][xlen-1:0] lane_data_t;
    typedef logic [num_threads-1:0] tmask_t;

    typedef struct packed {
        opcode_e             op;
        logic [nr_bits-1:0]  rd;
        logic [nr_bits-1:0]  rs1;
        logic [nr_bits-1:0]  rs2;
        logic [nr_bits-1:0]  rs3;
        logic [imm_bits-1:0] imm;
        tmask_t              tmask;
        logic                wb;
    } issue_t;

    typedef struct packed {
        opcode_e             op;
        logic [nr_bits-1:0]  rd;
        tmask_t              tmask;
        logic                wb;
        logic [imm_bits-1:0] imm;
        lane_data_t          rs1_data;
        lane_data_t          rs2_data;
        lane_data_t          rs3_data;
    } exec_t;

    typedef struct packed {
        logic [nr_bits-1:0] rd;
        tmask_t             tmask;
        logic               wb;
        lane_data_t         data;
    } result_t;

    typedef struct packed {
        logic [nr_bits-1:0] rd;
        tmask_t             tmask;
        lane_data_t         data;
    } wb_t;

endpackage

//--- simt_result.sv
////////////////////////////////////////
// SIMT result stage
// result beat and register write-back
////////////////////////////////////////
`timescale 1ns/10ps

module simt_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  simt_pkg::result_t in_data,
    output logic              result_valid,
    input  logic              result_ready,
    output simt_pkg::result_t result,
    output logic              wb_valid,
    output simt_pkg::wb_t     wb_data
);
    import simt_pkg::*;

    logic    valid_q;
    result_t data_q;

    assign in_ready = !valid_q || result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            data_q <= in_data;
        end
    end

    assign result_valid = valid_q;
    assign result       = data_q;

    // registers are only written once the result has left the slice
    assign wb_valid     = valid_q && result_ready && data_q.wb;
    assign wb_data.rd    = data_q.rd;
    assign wb_data.tmask = data_q.tmask;
    assign wb_data.data  = data_q.data;

endmodule

//--- simt_stage_buf.sv
////////////////////////////////////////
// SIMT stage buffer
// two-entry valid/ready skid buffer
////////////////////////////////////////
`timescale 1ns/10ps

module simt_stage_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     skid_valid;
    payload_t skid_data;
    logic     load_out;

    assign in_ready = !skid_valid;

    // the output register refills whenever it is empty or being drained
    assign load_out = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && !skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_valid && !skid_valid) begin
            skid_data <= in_data;
        end
    end

endmodule

//--- simt_tb.sv
////////////////////////////////////////
// SIMT issue slice testbench
// random programs against a model
////////////////////////////////////////
`timescale 1ns/10ps

module simt_tb;
    import simt_pkg::*;

    localparam int num_banks = 4;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        result_valid;
    logic        result_ready;
    result_t     result;

    logic [31:0] instr_list [$];
    result_t     exp_q [$];
    logic [31:0] model_regs [num_regs][num_threads];
    logic        ready_random;
    int          checked;
    int          seed_val;

    simt_core #(
        .num_banks (num_banks)
    ) simt_core_inst (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic value_error(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        $display("ERROR %s expected %h actual %h at result %0d", name, expected, actual,
                 checked);
        abort_run();
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [4:0] rs3, input logic [3:0] tmask);
        // the top nibble is unused and carries noise
        return {4'($urandom), tmask, rs3, rs2, rs1, rd, op};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom % num_regs);
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] r, input int t);
        return (r == 5'd0) ? 32'h0 : model_regs[r][t];
    endfunction

    // expected beat for one instruction, applied to the model in program order
    function automatic result_t model_exec(input logic [31:0] word);
        result_t     res;
        logic [3:0]  op;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] v;
        op        = word[3:0];
        rd        = word[8:4];
        res       = '0;
        res.rd    = rd;
        res.tmask = word[27:24];
        res.wb    = (rd != 5'd0);
        for (int t = 0; t < num_threads; t++) begin
            a = reg_value(word[13:9], t);
            b = reg_value(word[18:14], t);
            c = reg_value(word[23:19], t);
            case (op)
                op_add:  v = a + b;
                op_sub:  v = a - b;
                op_and:  v = a & b;
                op_or:   v = a | b;
                op_xor:  v = a ^ b;
                op_shl:  v = a << b[4:0];
                op_shr:  v = a >> b[4:0];
                op_mad:  v = a * b + c;
                op_ldi:  v = 32'(word[23:9]) + 32'(t);
                default: v = 32'h0;
            endcase
            if (!res.tmask[t]) begin
                v = 32'h0;
            end else if (rd != 5'd0) begin
                model_regs[rd][t] = v;
            end
            res.data[t] = v;
        end
        return res;
    endfunction

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rs3;
        logic [4:0]  prev_rd;
        logic [14:0] imm;
        logic [3:0]  op;
        logic [3:0]  mask;
        for (int r = 1; r < num_regs; r++) begin
            imm = 15'($urandom);
            instr_list.push_back(encode(op_ldi, 5'(r), imm[4:0], imm[9:5], imm[14:10], 4'hf));
        end
        for (int i = 0; i < 60; i++) begin
            op = 4'($urandom % 8);
            instr_list.push_back(encode(op, rand_reg(), rand_reg(), rand_reg(), rand_reg(),
                                        4'hf));
        end
        // sources forced into one bank, some of them identical
        for (int i = 0; i < 40; i++) begin
            rs1 = rand_reg();
            rs2 = 5'(rs1 + num_banks * ($urandom % (num_regs / num_banks)));
            rs3 = 5'(rs1 + num_banks * ($urandom % (num_regs / num_banks)));
            if (i % 5 == 0) begin
                rs2 = rs1;
                rs3 = rs1;
            end
            op = (i % 2 == 0) ? 4'(op_mad) : 4'($urandom % 8);
            instr_list.push_back(encode(op, rand_reg(), rs1, rs2, rs3, 4'hf));
        end
        prev_rd = 5'(1 + $urandom % 31);
        for (int i = 0; i < 30; i++) begin
            rd = 5'(1 + $urandom % 31);
            op = 4'($urandom % 8);
            rs2 = (i % 3 == 0) ? prev_rd : rand_reg();
            instr_list.push_back(encode(op, rd, prev_rd, rs2, prev_rd, 4'hf));
            prev_rd = rd;
        end
        // a partial write, then a full-mask copy of the same register
        for (int i = 0; i < 25; i++) begin
            rd   = 5'(1 + $urandom % 31);
            mask = 4'(1 + $urandom % 14);
            op   = 4'($urandom % 9);
            instr_list.push_back(encode(op, rd, rand_reg(), rand_reg(), rand_reg(), mask));
            instr_list.push_back(encode(op_or, rand_reg(), rd, 5'd0, rand_reg(), 4'hf));
        end
        for (int i = 0; i < 40; i++) begin
            op = 4'($urandom % 9);
            instr_list.push_back(encode(op, rand_reg(), rand_reg(), rand_reg(), rand_reg(),
                                        4'($urandom)));
        end
    endtask

    task automatic send_all();
        int   sent;
        logic fire;
        sent = 0;
        while (sent < instr_list.size()) begin
            if (($urandom % 4) != 0) begin
                instr_valid <= 1'b1;
                instr       <= instr_list[sent];
                fire = 1'b0;
                while (!fire) begin
                    @(negedge clk);
                    fire = (instr_ready === 1'b1);
                    @(posedge clk);
                end
                exp_q.push_back(model_exec(instr_list[sent]));
                sent++;
            end else begin
                instr_valid <= 1'b0;
                @(posedge clk);
            end
        end
        instr_valid <= 1'b0;
    endtask

    initial begin
        seed_val     = $urandom(32'h4613);
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = 32'h0;
        result_ready = 1'b0;
        ready_random = 1'b0;
        checked      = 0;
        for (int r = 0; r < num_regs; r++) begin
            for (int t = 0; t < num_threads; t++) begin
                model_regs[r][t] = 32'h0;
            end
        end
        build_program();
        repeat (3) @(posedge clk);
        reset        <= 1'b0;
        result_ready <= 1'b1;
        // an idle slice must stay quiet
        repeat (10) @(posedge clk);
        ready_random <= 1'b1;
        send_all();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if ((exp_q.size() == 0) && (checked == instr_list.size())) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d results checked for %0d instructions sent", checked,
                     instr_list.size());
            abort_run();
        end
    end

    initial begin : ready_driver
        forever begin
            @(posedge clk);
            if (ready_random) begin
                result_ready <= (($urandom % 3) != 0);
            end
        end
    end

    initial begin : monitor
        result_t exp;
        forever begin
            @(negedge clk);
            if (reset === 1'b1) begin
                assert (result_valid === 1'b0)
                    else plain_error("result_valid was high during reset");
                assert (instr_ready === 1'b0)
                    else plain_error("instr_ready was high during reset");
            end else begin
                assert (!$isunknown(result_valid))
                    else plain_error("result_valid is unknown after reset");
                if (result_valid === 1'b1) begin
                    assert (exp_q.size() != 0)
                        else plain_error("a result appeared with no instruction outstanding");
                    if (result_ready === 1'b1) begin
                        exp = exp_q.pop_front();
                        assert (result.rd === exp.rd)
                            else value_error("result.rd", 128'(exp.rd), 128'(result.rd));
                        assert (result.tmask === exp.tmask)
                            else value_error("result.tmask", 128'(exp.tmask), 128'(result.tmask));
                        assert (result.wb === exp.wb)
                            else value_error("result.wb", 128'(exp.wb), 128'(result.wb));
                        assert (result.data === exp.data)
                            else value_error("result.data", exp.data, result.data);
                        checked++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge clk);
        limit = instr_list.size() * 20 + 200;
        repeat (limit) @(posedge clk);
        $display("the run timed out after %0d cycles with %0d results still outstanding",
                 limit, exp_q.size());
        abort_run();
    end

endmodule
